// File: verilog.f
hdl/wh_link_pkg.sv
hdl/wh_node_pkg.sv
hdl/wh_flit_serializer.sv
hdl/wh_flit_deserializer.sv
hdl/wh_traffic_master.sv
hdl/wh_loopback_slave.sv
hdl/wh_test_pair_top.sv
verification/wh_test_pair_sva.sv
verification/wh_test_pair_tb.sv

// File: Bender.yml
package:
  name: wh_test_pair

sources:
  # packages first, then the design tree bottom up
  - files:
      - hdl/wh_link_pkg.sv
      - hdl/wh_node_pkg.sv
      - hdl/wh_flit_serializer.sv
      - hdl/wh_flit_deserializer.sv
      - hdl/wh_traffic_master.sv
      - hdl/wh_loopback_slave.sv
      - hdl/wh_test_pair_top.sv
  - target: test
    files:
      - verification/wh_test_pair_sva.sv
      - verification/wh_test_pair_tb.sv

// File: verification/wh_test_pair_tb.sv
// testbench for the master and slave test pair
// clock, reset, watchdog, xorshift source, compare tasks and directed tests

`timescale 1ns/10ps

module wh_test_pair_tb;

  localparam int clk_period    = 8;
  localparam int reset_cycles  = 2;
  localparam int burst_cycles  = 40;
  localparam int stall_cycles  = 40;
  localparam int stall_hold    = 8;
  localparam int random_cycles = 200;
  localparam int misroute_hold = 10;
  localparam int send_limit    = 20;
  localparam int drain_limit   = 100;
  localparam int settle_cycles = 8;
  localparam int flit_width    = wh_link_pkg::flit_width_default;
  localparam int req_flits     = ($bits(wh_node_pkg::wh_req_pkt_s) + flit_width - 1)
                                 / flit_width;
  // the serializer takes a new packet every req_flits + 1 edges
  localparam int burst_packets = (burst_cycles + req_flits) / (req_flits + 1);
  // every test phase plus its drain and reset budget
  localparam int total_cycles  = 3 * (reset_cycles + 2) + burst_cycles + stall_cycles
                                 + stall_hold + random_cycles + misroute_hold + send_limit
                                 + 4 * (drain_limit + settle_cycles);
  localparam int watchdog_ns   = total_cycles * clk_period * 2;

  logic                                 mc_clk_i;
  logic                                 mc_reset_i;
  logic                                 mc_en_i;
  logic [wh_link_pkg::x_cord_width-1:0] master_x_i;
  logic [wh_link_pkg::y_cord_width-1:0] master_y_i;
  logic [wh_link_pkg::x_cord_width-1:0] slave_x_i;
  logic [wh_link_pkg::y_cord_width-1:0] slave_y_i;
  logic [wh_link_pkg::x_cord_width-1:0] dest_x_i;
  logic                                 slave_busy_i;
  logic                                 error_o;
  logic [31:0]                          sent_o;
  logic [31:0]                          received_o;
  logic [31:0]                          rng_state;

  wh_test_pair_top #(
    .flit_width_p(flit_width)
  ) i_dut (
    .mc_clk_i    (mc_clk_i),
    .mc_reset_i  (mc_reset_i),
    .mc_en_i     (mc_en_i),
    .master_x_i  (master_x_i),
    .master_y_i  (master_y_i),
    .slave_x_i   (slave_x_i),
    .slave_y_i   (slave_y_i),
    .dest_x_i    (dest_x_i),
    .slave_busy_i(slave_busy_i),
    .error_o     (error_o),
    .sent_o      (sent_o),
    .received_o  (received_o)
  );

  bind wh_flit_serializer wh_test_pair_sva #(
    .flit_width_p(flit_width_p),
    .pkt_t       (pkt_t)
  ) i_sva (
    .mc_clk_i    (mc_clk_i),
    .mc_reset_i  (mc_reset_i),
    .pkt_valid_i (pkt_valid_i),
    .pkt_ready_o (pkt_ready_o),
    .link_o      (link_o),
    .link_ready_i(link_ready_i)
  );

  initial
  begin
    mc_clk_i = 1'b0;
    forever #(clk_period / 2) mc_clk_i = ~mc_clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic compare_count(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      abort_run("count check failed");
    end
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      abort_run("flag check failed");
    end
  endtask

  task automatic apply_reset();
    @(negedge mc_clk_i);
    mc_reset_i = 1'b1;
    repeat (reset_cycles) @(negedge mc_clk_i);
    mc_reset_i = 1'b0;
  endtask

  // every request in flight has come back
  // then a quiet spell so stray responses show up
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (received_o != sent_o)
    begin
      if (cycles >= drain_limit)
        abort_run("responses did not catch up with requests in time");
      @(negedge mc_clk_i);
      cycles++;
    end
    repeat (settle_cycles) @(negedge mc_clk_i);
  endtask

  task automatic check_reset_state();
    compare_flag("error_o after reset", error_o, 1'b0);
    compare_count("sent_o after reset", sent_o, 32'd0);
    compare_count("received_o after reset", received_o, 32'd0);
  endtask

  task automatic burst_traffic();
    dest_x_i = slave_x_i;
    mc_en_i  = 1'b1;
    repeat (burst_cycles) @(negedge mc_clk_i);
    mc_en_i = 1'b0;
    wait_drain();
    compare_count("burst sent_o", sent_o, burst_packets);
    compare_count("burst received_o", received_o, sent_o);
    compare_flag("burst error_o", error_o, 1'b0);
  endtask

  task automatic stall_under_back_pressure();
    logic [31:0] stalled;
    slave_busy_i = 1'b1;
    mc_en_i      = 1'b1;
    repeat (stall_cycles) @(negedge mc_clk_i);
    stalled = sent_o;
    repeat (stall_hold) @(negedge mc_clk_i);
    compare_count("sent_o under back-pressure", sent_o, stalled);
    compare_flag("at most four outstanding", (sent_o - received_o) <= 32'd4, 1'b1);
    mc_en_i      = 1'b0;
    slave_busy_i = 1'b0;
    wait_drain();
    compare_count("received_o after release", received_o, sent_o);
    compare_flag("back-pressure error_o", error_o, 1'b0);
  endtask

  task automatic random_enable_traffic();
    repeat (random_cycles)
    begin
      @(negedge mc_clk_i);
      compare_flag("at most four outstanding", (sent_o - received_o) <= 32'd4, 1'b1);
      rng_state    = xorshift(rng_state);
      mc_en_i      = rng_state[0];
      slave_busy_i = (rng_state[5:4] == 2'b00);
    end
    mc_en_i      = 1'b0;
    slave_busy_i = 1'b0;
    wait_drain();
    compare_count("random received_o", received_o, sent_o);
    compare_flag("random error_o", error_o, 1'b0);
  endtask

  // one packet to the wrong column must raise the slave route error
  task automatic misroute_detection();
    logic [31:0] start;
    int          cycles;
    start    = sent_o;
    cycles   = 0;
    dest_x_i = slave_x_i + 1'b1;
    mc_en_i  = 1'b1;
    while (sent_o == start)
    begin
      if (cycles >= send_limit)
        abort_run("the misrouted request was never accepted");
      @(negedge mc_clk_i);
      cycles++;
    end
    mc_en_i = 1'b0;
    compare_count("misroute packets sent", sent_o, start + 32'd1);
    wait_drain();
    compare_flag("error_o after misroute", error_o, 1'b1);
    repeat (misroute_hold)
    begin
      @(negedge mc_clk_i);
      compare_flag("error_o stays set", error_o, 1'b1);
    end
    apply_reset();
    compare_flag("error_o cleared by reset", error_o, 1'b0);
  endtask

  initial
  begin
    #(watchdog_ns);
    abort_run("watchdog expired before the tests finished");
  end

  initial
  begin
    wait ((i_dut.fwd_ser.i_sva.fail_count != 0) || (i_dut.rev_ser.i_sva.fail_count != 0));
    abort_run("a flit link assertion failed in a serializer");
  end

  initial
  begin
    mc_reset_i   = 1'b1;
    mc_en_i      = 1'b0;
    master_x_i   = 4'd2;
    master_y_i   = 4'd1;
    slave_x_i    = 4'd5;
    slave_y_i    = 4'd3;
    dest_x_i     = 4'd5;
    slave_busy_i = 1'b0;
    rng_state    = 32'd77;
    apply_reset();
    check_reset_state();
    burst_traffic();
    stall_under_back_pressure();
    random_enable_traffic();
    misroute_detection();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: verification/wh_test_pair_sva.sv
// flit link and packet handshake assertions for the serializer
// attached to every wh_flit_serializer instance through bind

`timescale 1ns/10ps

module wh_test_pair_sva #(
  parameter int flit_width_p = 16,
  parameter type pkt_t = logic [31:0]
) (
  input logic                       mc_clk_i,
  input logic                       mc_reset_i,
  input logic                       pkt_valid_i,
  input logic                       pkt_ready_o,
  input wh_link_pkg::wh_flit_link_s link_o,
  input logic                       link_ready_i
);

  localparam int num_flits_lp = ($bits(pkt_t) + flit_width_p - 1) / flit_width_p;

  int fail_count = 0;
  int flits_left_q;

  // flits of the held packet still to go out on the link
  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
      flits_left_q <= 0;
    else if (pkt_valid_i && pkt_ready_o)
      flits_left_q <= num_flits_lp;
    else if (link_o.v && link_ready_i && (flits_left_q != 0))
      flits_left_q <= flits_left_q - 1;
  end

  // flit held steady under back-pressure
  a_flit_stable: assert property (@(posedge mc_clk_i) disable iff (mc_reset_i)
    (link_o.v && !link_ready_i) |=> (link_o.v && $stable(link_o.data)))
  else
  begin
    fail_count++;
    $error("flit changed while the link was stalled");
  end

  // a held packet blocks the next one
  a_no_accept_when_held: assert property (@(posedge mc_clk_i) disable iff (mc_reset_i)
    (pkt_valid_i && pkt_ready_o) |-> (flits_left_q == 0))
  else
  begin
    fail_count++;
    $error("packet accepted while another packet was held");
  end

  a_valid_low_in_reset: assert property (@(posedge mc_clk_i)
    mc_reset_i |=> !link_o.v)
  else
  begin
    fail_count++;
    $error("flit valid high after a reset edge");
  end

endmodule

// File: hdl/wh_test_pair_top.sv
// master and slave test pair
// forward and reverse flit links, each with a serializer and deserializer

`timescale 1ns/10ps

module wh_test_pair_top #(
  parameter int flit_width_p = wh_link_pkg::flit_width_default
) (
  input  logic                                 mc_clk_i,
  input  logic                                 mc_reset_i,
  input  logic                                 mc_en_i,
  input  logic [wh_link_pkg::x_cord_width-1:0] master_x_i,
  input  logic [wh_link_pkg::y_cord_width-1:0] master_y_i,
  input  logic [wh_link_pkg::x_cord_width-1:0] slave_x_i,
  input  logic [wh_link_pkg::y_cord_width-1:0] slave_y_i,
  input  logic [wh_link_pkg::x_cord_width-1:0] dest_x_i,
  input  logic                                 slave_busy_i,
  output logic                                 error_o,
  output logic [31:0]                          sent_o,
  output logic [31:0]                          received_o
);

  // master to fwd_ser
  logic                      mst_req_valid;
  logic                      mst_req_ready;
  wh_node_pkg::wh_req_pkt_s  mst_req;

  // fwd_des to slave
  logic                      slv_req_valid;
  logic                      slv_req_ready;
  wh_node_pkg::wh_req_pkt_s  slv_req;

  // slave to rev_ser
  logic                      slv_resp_valid;
  logic                      slv_resp_ready;
  wh_node_pkg::wh_resp_pkt_s slv_resp;

  // rev_des to master
  logic                      mst_resp_valid;
  wh_node_pkg::wh_resp_pkt_s mst_resp;

  wh_link_pkg::wh_flit_link_s fwd_link;
  logic                       fwd_link_ready;
  wh_link_pkg::wh_flit_link_s rev_link;
  logic                       rev_link_ready;

  logic master_error;
  logic route_error;

  wh_traffic_master #(
    .flit_width_p(flit_width_p)
  ) i_master (
    .mc_clk_i    (mc_clk_i),
    .mc_reset_i  (mc_reset_i),
    .mc_en_i     (mc_en_i),
    .my_x_i      (master_x_i),
    .my_y_i      (master_y_i),
    .dest_x_i    (dest_x_i),
    .req_valid_o (mst_req_valid),
    .req_o       (mst_req),
    .req_ready_i (mst_req_ready),
    .resp_valid_i(mst_resp_valid),
    .resp_i      (mst_resp),
    .error_o     (master_error),
    .sent_o      (sent_o),
    .received_o  (received_o)
  );

  wh_flit_serializer #(
    .flit_width_p(flit_width_p),
    .pkt_t       (wh_node_pkg::wh_req_pkt_s)
  ) fwd_ser (
    .mc_clk_i    (mc_clk_i),
    .mc_reset_i  (mc_reset_i),
    .pkt_valid_i (mst_req_valid),
    .pkt_i       (mst_req),
    .pkt_ready_o (mst_req_ready),
    .link_o      (fwd_link),
    .link_ready_i(fwd_link_ready)
  );

  wh_flit_deserializer #(
    .flit_width_p(flit_width_p),
    .pkt_t       (wh_node_pkg::wh_req_pkt_s)
  ) fwd_des (
    .mc_clk_i    (mc_clk_i),
    .mc_reset_i  (mc_reset_i),
    .link_i      (fwd_link),
    .link_ready_o(fwd_link_ready),
    .pkt_valid_o (slv_req_valid),
    .pkt_o       (slv_req),
    .pkt_ready_i (slv_req_ready)
  );

  wh_loopback_slave #(
    .flit_width_p(flit_width_p)
  ) i_slave (
    .mc_clk_i     (mc_clk_i),
    .mc_reset_i   (mc_reset_i),
    .my_x_i       (slave_x_i),
    .my_y_i       (slave_y_i),
    .slave_busy_i (slave_busy_i),
    .req_valid_i  (slv_req_valid),
    .req_i        (slv_req),
    .req_ready_o  (slv_req_ready),
    .resp_valid_o (slv_resp_valid),
    .resp_o       (slv_resp),
    .resp_ready_i (slv_resp_ready),
    .route_error_o(route_error)
  );

  wh_flit_serializer #(
    .flit_width_p(flit_width_p),
    .pkt_t       (wh_node_pkg::wh_resp_pkt_s)
  ) rev_ser (
    .mc_clk_i    (mc_clk_i),
    .mc_reset_i  (mc_reset_i),
    .pkt_valid_i (slv_resp_valid),
    .pkt_i       (slv_resp),
    .pkt_ready_o (slv_resp_ready),
    .link_o      (rev_link),
    .link_ready_i(rev_link_ready)
  );

  // master always accepts responses
  wh_flit_deserializer #(
    .flit_width_p(flit_width_p),
    .pkt_t       (wh_node_pkg::wh_resp_pkt_s)
  ) rev_des (
    .mc_clk_i    (mc_clk_i),
    .mc_reset_i  (mc_reset_i),
    .link_i      (rev_link),
    .link_ready_o(rev_link_ready),
    .pkt_valid_o (mst_resp_valid),
    .pkt_o       (mst_resp),
    .pkt_ready_i (1'b1)
  );

  assign error_o = master_error | route_error;

endmodule

// File: hdl/wh_loopback_slave.sv
// loopback slave node
// checks the arrival coordinate and turns each request into a response

`timescale 1ns/10ps

module wh_loopback_slave #(
  parameter int flit_width_p = 16
) (
  input  logic                                 mc_clk_i,
  input  logic                                 mc_reset_i,
  input  logic [wh_link_pkg::x_cord_width-1:0] my_x_i,
  input  logic [wh_link_pkg::y_cord_width-1:0] my_y_i,
  input  logic                                 slave_busy_i,
  input  logic                                 req_valid_i,
  input  wh_node_pkg::wh_req_pkt_s             req_i,
  output logic                                 req_ready_o,
  output logic                                 resp_valid_o,
  output wh_node_pkg::wh_resp_pkt_s            resp_o,
  input  logic                                 resp_ready_i,
  output logic                                 route_error_o
);

  localparam int resp_width_lp = $bits(wh_node_pkg::wh_resp_pkt_s);
  localparam int resp_flits_lp = (resp_width_lp + flit_width_p - 1) / flit_width_p;

  logic req_take;

  // busy holds the request in the deserializer upstream
  assign resp_valid_o = req_valid_i & ~slave_busy_i;
  assign req_ready_o  = resp_ready_i & ~slave_busy_i;
  assign req_take     = req_valid_i & req_ready_o;

  // send it back where it came from
  assign resp_o.hdr.cord = req_i.src_x;
  assign resp_o.hdr.len  = wh_link_pkg::len_width'(resp_flits_lp - 1);
  assign resp_o.src_x    = my_x_i;
  assign resp_o.src_y    = my_y_i;
  assign resp_o.load     = req_i.load;

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
      route_error_o <= 1'b0;
    else if (req_take && (req_i.hdr.cord != my_x_i))
      route_error_o <= 1'b1;
  end

endmodule

// File: hdl/wh_traffic_master.sv
// traffic master node
// counting payload generator, request builder, response checker
// and the sent and received packet counters

`timescale 1ns/10ps

module wh_traffic_master #(
  parameter int flit_width_p = 16
) (
  input  logic                                 mc_clk_i,
  input  logic                                 mc_reset_i,
  input  logic                                 mc_en_i,
  input  logic [wh_link_pkg::x_cord_width-1:0] my_x_i,
  input  logic [wh_link_pkg::y_cord_width-1:0] my_y_i,
  input  logic [wh_link_pkg::x_cord_width-1:0] dest_x_i,
  output logic                                 req_valid_o,
  output wh_node_pkg::wh_req_pkt_s             req_o,
  input  logic                                 req_ready_i,
  input  logic                                 resp_valid_i,
  input  wh_node_pkg::wh_resp_pkt_s            resp_i,
  output logic                                 error_o,
  output logic [31:0]                          sent_o,
  output logic [31:0]                          received_o
);

  localparam int req_width_lp = $bits(wh_node_pkg::wh_req_pkt_s);
  localparam int req_flits_lp = (req_width_lp + flit_width_p - 1) / flit_width_p;

  logic [wh_node_pkg::payload_width-1:0] send_gen_r;
  logic [wh_node_pkg::payload_width-1:0] check_gen_r;
  logic                                  req_xfer;
  logic                                  resp_xfer;
  logic                                  load_bad;
  logic                                  cord_bad;

  // response ready is tied high at the top, so valid alone is a transfer
  assign req_valid_o = mc_en_i;
  assign req_xfer    = req_valid_o & req_ready_i;
  assign resp_xfer   = resp_valid_i;

  assign req_o.hdr.cord = dest_x_i;
  assign req_o.hdr.len  = wh_link_pkg::len_width'(req_flits_lp - 1);
  assign req_o.src_x    = my_x_i;
  assign req_o.src_y    = my_y_i;
  assign req_o.load     = send_gen_r;

  // responses come back in send order, so a second counter predicts them
  assign load_bad = (resp_i.load != check_gen_r);
  assign cord_bad = (resp_i.hdr.cord != my_x_i);

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      send_gen_r  <= '0;
      check_gen_r <= '0;
      sent_o      <= '0;
      received_o  <= '0;
      error_o     <= 1'b0;
    end
    else
    begin
      if (req_xfer)
      begin
        send_gen_r <= send_gen_r + 1'b1;
        sent_o     <= sent_o + 1'b1;
      end
      if (resp_xfer)
      begin
        check_gen_r <= check_gen_r + 1'b1;
        received_o  <= received_o + 1'b1;
        // sticky until reset
        if (load_bad || cord_bad)
          error_o <= 1'b1;
      end
    end
  end

endmodule

// File: hdl/wh_flit_deserializer.sv
// flit to packet deserializer
// collects flits into an assembly register, then offers the whole packet

`timescale 1ns/10ps

module wh_flit_deserializer #(
  parameter int flit_width_p = 16,
  parameter type pkt_t = logic [31:0]
) (
  input  logic                       mc_clk_i,
  input  logic                       mc_reset_i,
  input  wh_link_pkg::wh_flit_link_s link_i,
  output logic                       link_ready_o,
  output logic                       pkt_valid_o,
  output pkt_t                       pkt_o,
  input  logic                       pkt_ready_i
);

  localparam int pkt_width_lp = $bits(pkt_t);
  localparam int num_flits_lp = (pkt_width_lp + flit_width_p - 1) / flit_width_p;
  localparam int buf_width_lp = num_flits_lp * flit_width_p;
  localparam int cnt_width_lp = (num_flits_lp > 1) ? $clog2(num_flits_lp) : 1;

  typedef logic [flit_width_p-1:0] flit_t;

  logic [buf_width_lp-1:0] asm_r;
  logic [cnt_width_lp-1:0] flit_cnt_r;
  logic                    full_r;
  logic                    flit_xfer;
  logic                    pkt_xfer;
  logic                    last_flit;
  flit_t                   flit;

  assign flit         = flit_t'(link_i.data);
  assign link_ready_o = ~full_r;
  assign flit_xfer    = link_i.v & link_ready_o;
  assign pkt_xfer     = pkt_valid_o & pkt_ready_i;
  assign last_flit    = (flit_cnt_r == cnt_width_lp'(num_flits_lp - 1));

  assign pkt_valid_o = full_r;
  // padding bits of the last flit are dropped here
  assign pkt_o       = pkt_t'(asm_r[pkt_width_lp-1:0]);

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      full_r     <= 1'b0;
      flit_cnt_r <= '0;
    end
    else if (flit_xfer)
    begin
      if (last_flit)
      begin
        full_r     <= 1'b1;
        flit_cnt_r <= '0;
      end
      else
        flit_cnt_r <= flit_cnt_r + 1'b1;
    end
    else if (pkt_xfer)
      full_r <= 1'b0;
  end

  // each flit lands in the slot given by the counter
  always_ff @(posedge mc_clk_i)
  begin
    if (flit_xfer)
      asm_r[flit_cnt_r*flit_width_p +: flit_width_p] <= flit;
  end

endmodule

// File: hdl/wh_flit_serializer.sv
// packet to flit serializer
// holds one packet in a shift register and sends it lowest flit first

`timescale 1ns/10ps

module wh_flit_serializer #(
  parameter int flit_width_p = 16,
  parameter type pkt_t = logic [31:0]
) (
  input  logic                       mc_clk_i,
  input  logic                       mc_reset_i,
  input  logic                       pkt_valid_i,
  input  pkt_t                       pkt_i,
  output logic                       pkt_ready_o,
  output wh_link_pkg::wh_flit_link_s link_o,
  input  logic                       link_ready_i
);

  localparam int pkt_width_lp = $bits(pkt_t);
  localparam int num_flits_lp = (pkt_width_lp + flit_width_p - 1) / flit_width_p;
  localparam int buf_width_lp = num_flits_lp * flit_width_p;
  localparam int cnt_width_lp = (num_flits_lp > 1) ? $clog2(num_flits_lp) : 1;

  typedef logic [buf_width_lp-1:0] buf_t;
  typedef logic [wh_link_pkg::flit_width_default-1:0] link_data_t;

  buf_t                    shift_r;
  logic [cnt_width_lp-1:0] flit_cnt_r;
  logic                    busy_r;
  logic                    pkt_xfer;
  logic                    flit_xfer;
  logic                    last_flit;

  assign pkt_ready_o = ~busy_r;
  assign pkt_xfer    = pkt_valid_i & pkt_ready_o;
  assign flit_xfer   = link_o.v & link_ready_i;
  assign last_flit   = (flit_cnt_r == cnt_width_lp'(num_flits_lp - 1));

  // flit 0 is always the low slice of the register
  assign link_o.v    = busy_r;
  assign link_o.data = link_data_t'(shift_r[flit_width_p-1:0]);

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      busy_r     <= 1'b0;
      flit_cnt_r <= '0;
    end
    else if (pkt_xfer)
    begin
      busy_r     <= 1'b1;
      flit_cnt_r <= '0;
    end
    else if (flit_xfer)
    begin
      // free again once the last flit is gone
      if (last_flit)
        busy_r <= 1'b0;
      flit_cnt_r <= flit_cnt_r + 1'b1;
    end
  end

  // payload path
  always_ff @(posedge mc_clk_i)
  begin
    if (pkt_xfer)
      shift_r <= buf_t'(pkt_i);
    else if (flit_xfer)
      shift_r <= shift_r >> flit_width_p;
  end

endmodule

// File: hdl/wh_node_pkg.sv
// packet level definitions
// payload width plus the request and response packet layouts

package wh_node_pkg;

  // width of the counting payload
  localparam int payload_width = 32;

  // request from master to slave
  // hdr ends up in the low bits and is sent first
  typedef struct packed {
    logic [payload_width-1:0]             load;
    logic [wh_link_pkg::y_cord_width-1:0] src_y;
    logic [wh_link_pkg::x_cord_width-1:0] src_x;
    wh_link_pkg::wh_header_s              hdr;
  } wh_req_pkt_s;

  // response from slave back to master
  // same field layout as the request
  typedef struct packed {
    logic [payload_width-1:0]             load;
    logic [wh_link_pkg::y_cord_width-1:0] src_y;
    logic [wh_link_pkg::x_cord_width-1:0] src_x;
    wh_link_pkg::wh_header_s              hdr;
  } wh_resp_pkt_s;

endpackage

// File: hdl/wh_link_pkg.sv
// flit link level definitions
// coordinate and header field widths, routing header and flit link struct

package wh_link_pkg;

  // coordinate widths
  // y is carried but never routed on
  localparam int x_cord_width = 4;
  localparam int y_cord_width = 4;

  // number of flits that follow the header flit
  localparam int len_width = 4;

  // flit width used when the top level is not overridden
  localparam int flit_width_default = 16;

  // routing header
  // cord sits in the low bits so it leaves in flit 0
  typedef struct packed {
    logic [len_width-1:0]    len;
    logic [x_cord_width-1:0] cord;
  } wh_header_s;

  // one direction of a flit link
  // ready runs on its own wire from the receiver
  typedef struct packed {
    logic                          v;
    logic [flit_width_default-1:0] data;
  } wh_flit_link_s;

endpackage
